// ==== sources.f ====
+incdir+verilog
verilog/nnLayerPkg.sv
verilog/layerControl.sv
verilog/weightBank.sv
verilog/neuronNode.sv
verilog/nnLayer.sv
testbench/nnLayer_assert.sv
testbench/nnLayerTb.sv

// ==== testbench/nnLayerTb.sv ====
`include "nnLayer_params.svh"

module nnLayerTb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [1:0] respOkay = 2'b00;
	localparam logic [1:0] respSlvErr = 2'b10;

	typedef enum {wZero, wLfsr, wFixed} weightPatT;
	typedef enum {aZero, aOnes, aLfsr, aExtreme} actPatT;
	typedef struct {
		weightPatT wPat;
		actPatT aPat;
		logic [11:0] probeAddr; // extra write after each run.
		logic [1:0] probeResp;
		int bHold;
		int rHold;
	} rowT;

	localparam int numRows = 8;
	localparam int rowAccesses = 2 * (`NN_INPUTS + `NN_NEURONS * (`NN_INPUTS + 1)) + 20;
	localparam int watchdogCycles = numRows * (200 + 8 * rowAccesses) + 200;

	rowT stimRows [numRows] = '{
		'{wZero, aZero, 12'h0C0, respSlvErr, 0, 0},
		'{wFixed, aOnes, 12'h080, respSlvErr, 3, 0},
		'{wLfsr, aLfsr, 12'h044, respSlvErr, 0, 4},
		'{wFixed, aExtreme, 12'h040, respOkay, 5, 5},
		'{wLfsr, aExtreme, 12'h03C, respSlvErr, 0, 0},
		'{wLfsr, aLfsr, 12'h200, respSlvErr, 2, 2},
		'{wZero, aLfsr, 12'h08C, respSlvErr, 0, 0},
		'{wLfsr, aOnes, 12'h102, respSlvErr, 1, 3}
	};

	logic clk;
	logic reset;
	logic [`NN_ADDR_W-1:0] awAddr, arAddr;
	logic awValid, awReady, wValid, wReady, bValid, bReady;
	logic arValid, arReady, rValid, rReady;
	logic [`NN_AXI_DATA_W-1:0] wData, rData;
	logic [1:0] bResp, rResp;

	logic [31:0] lfsr = 32'hb129;
	logic [7:0] actMem [`NN_INPUTS];
	logic [7:0] wMem [`NN_NEURONS][`NN_INPUTS + 1]; // last slot is the bias.
	int cycleCount = 0;
	int acceptCycle;
	int valueErrors = 0;
	int otherErrors = 0;

	nnLayer u_nnLayer (.*);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk)
		cycleCount <= cycleCount + 1;

	initial
	begin
		repeat (watchdogCycles) @(posedge clk);
		$display("timeout: run still going after %0d clock cycles", watchdogCycles);
		$display("TB FAILED");
		$finish;
	end

	// galois lfsr, one step per bit.
	function automatic logic [7:0] randByte();
		logic [7:0] b;
		for (int k = 0; k < 8; k++)
		begin
			b = {b[6:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
		end
		return b;
	endfunction

	// low byte of each signed product, all wrapped mod 256, then relu.
	function automatic logic [7:0] expectResult(int n);
		logic [7:0] acc;
		logic signed [15:0] prod;
		acc = wMem[n][`NN_INPUTS];
		for (int i = 0; i < `NN_INPUTS; i++)
		begin
			prod = $signed(actMem[i]) * $signed(wMem[n][i]);
			acc = acc + prod[7:0];
		end
		return acc[7] ? 8'h00 : acc;
	endfunction

	task automatic fillPatterns(input rowT row);
		for (int n = 0; n < `NN_NEURONS; n++)
			for (int i = 0; i <= `NN_INPUTS; i++)
				case (row.wPat)
					wZero: wMem[n][i] = 8'h00;
					wLfsr: wMem[n][i] = randByte();
					default: wMem[n][i] = (i == `NN_INPUTS) ? 8'(8'h30 * n) :
						(((i + n) % 2) ? 8'h81 : 8'h7F);
				endcase
		for (int i = 0; i < `NN_INPUTS; i++)
			case (row.aPat)
				aZero: actMem[i] = 8'h00;
				aOnes: actMem[i] = 8'h01;
				aLfsr: actMem[i] = randByte();
				default: actMem[i] = (i % 2) ? 8'h7F : 8'h80;
			endcase
	endtask

	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
		else
		begin
			valueErrors++;
			$display("** Error: %s is %h, expected %h", name, got, exp);
		end
	endtask

	task automatic axiWrite(input logic [11:0] addr, input logic [31:0] data,
			input logic [1:0] expResp, input int hold);
		logic [1:0] heldResp;
		@(negedge clk);
		awAddr = addr;
		wData = data;
		awValid = 1'b1;
		wValid = 1'b1;
		bReady = (hold == 0);
		do
			@(negedge clk);
		while (!awReady);
		checkValue($sformatf("wReady at %h", addr), wReady, 1); // data goes with the address.
		acceptCycle = cycleCount + 1; // taken at the coming edge.
		@(negedge clk);
		checkValue($sformatf("wReady after %h", addr), wReady, 0);
		awValid = 1'b0;
		wValid = 1'b0;
		heldResp = bResp;
		repeat (hold)
		begin
			@(negedge clk);
			assert (bValid && bResp === heldResp)
			else
			begin
				otherErrors++;
				$display("write response to %h not held while bReady was low", addr);
			end
		end
		bReady = 1'b1;
		checkValue($sformatf("bValid at %h", addr), bValid, 1);
		checkValue($sformatf("bResp at %h", addr), bResp, expResp);
		@(negedge clk);
		bReady = 1'b0;
	endtask

	task automatic axiRead(input logic [11:0] addr, output logic [31:0] data,
			input logic [1:0] expResp, input int hold);
		logic [31:0] heldData;
		@(negedge clk);
		arAddr = addr;
		arValid = 1'b1;
		rReady = (hold == 0);
		do
			@(negedge clk);
		while (!arReady);
		acceptCycle = cycleCount + 1;
		@(negedge clk);
		arValid = 1'b0;
		heldData = rData;
		repeat (hold)
		begin
			@(negedge clk);
			assert (rValid && rData === heldData)
			else
			begin
				otherErrors++;
				$display("read data from %h not held while rReady was low", addr);
			end
		end
		rReady = 1'b1;
		checkValue($sformatf("rValid at %h", addr), rValid, 1);
		checkValue($sformatf("rResp at %h", addr), rResp, expResp);
		data = rData;
		@(negedge clk);
		rReady = 1'b0;
	endtask

	task automatic readCheck(input logic [11:0] addr, input logic [31:0] exp, input int hold);
		logic [31:0] d;
		axiRead(addr, d, respOkay, hold);
		checkValue($sformatf("rData at %h", addr), d, exp);
	endtask

	initial
	begin
		logic [31:0] d;
		logic [1:0] expStatus;
		int startCycle;
		int polls;
		int assertFails;
		reset = 1'b1;
		awAddr = '0;
		awValid = 1'b0;
		wData = '0;
		wValid = 1'b0;
		bReady = 1'b0;
		arAddr = '0;
		arValid = 1'b0;
		rReady = 1'b0;
		repeat (16) @(negedge clk);
		reset = 1'b0;
		readCheck(`NN_STATUS_ADDR, 32'h0, 0);
		for (int n = 0; n < `NN_NEURONS; n++)
			readCheck(12'(`NN_RESULT_BASE + 4 * n), 32'h0, 0);
		for (int r = 0; r < numRows; r++)
		begin
			fillPatterns(stimRows[r]);
			for (int i = 0; i < `NN_INPUTS; i++)
				axiWrite(12'(`NN_ACT_BASE + 4 * i), {24'h5A5A5A, actMem[i]}, respOkay, 0);
			for (int n = 0; n < `NN_NEURONS; n++)
				for (int i = 0; i <= `NN_INPUTS; i++)
					axiWrite(12'(`NN_WEIGHT_BASE + 64 * n + 4 * i), {24'hA5A5A5, wMem[n][i]},
						respOkay, 0);
			axiWrite(`NN_CTRL_ADDR, 32'h1, respOkay, 0);
			startCycle = acceptCycle;
			polls = 0;
			d = '0;
			// busy from the edge after start, done from the fifth.
			while (!d[1] && polls < 20)
			begin
				axiRead(`NN_STATUS_ADDR, d, respOkay, 0);
				expStatus = (acceptCycle - startCycle >= 5) ? 2'b10 : 2'b01;
				checkValue("rData (status)", d, {30'h0, expStatus});
				polls++;
			end
			assert (d[1] === 1'b1)
			else
			begin
				otherErrors++;
				$display("run %0d never reported done", r);
			end
			axiWrite(stimRows[r].probeAddr, 32'hFFFF_FFFE, stimRows[r].probeResp,
				stimRows[r].bHold);
			readCheck(`NN_STATUS_ADDR, 32'h2, 0);
			// whole register file read back after the probe.
			for (int i = 0; i < `NN_INPUTS; i++)
				readCheck(12'(`NN_ACT_BASE + 4 * i), {24'h0, actMem[i]}, 0);
			for (int n = 0; n < `NN_NEURONS; n++)
				for (int i = 0; i <= `NN_INPUTS; i++)
					readCheck(12'(`NN_WEIGHT_BASE + 64 * n + 4 * i), {24'h0, wMem[n][i]}, 0);
			for (int n = 0; n < `NN_NEURONS; n++)
				readCheck(12'(`NN_RESULT_BASE + 4 * n), {24'h0, expectResult(n)},
					stimRows[r].rHold);
		end
		repeat (8) @(negedge clk);
		assertFails = u_nnLayer.uControl.uAssert.failCount;
		$display("value errors %0d, other errors %0d, assertion failures %0d",
			valueErrors, otherErrors, assertFails);
		if (valueErrors + otherErrors + assertFails == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// ==== testbench/nnLayer_assert.sv ====
`include "nnLayer_params.svh"

module nnLayer_assert (
	input logic clk,
	input logic reset,
	input logic bValid,
	input logic bReady,
	input logic [1:0] bResp,
	input logic rValid,
	input logic rReady,
	input logic [`NN_AXI_DATA_W-1:0] rData,
	input logic busy,
	input logic done,
	input logic runValid
);
	timeunit 1ns;
	timeprecision 100ps;

	int failCount = 0;

	bHeld: assert property (@(posedge clk) disable iff (reset)
		bValid && !bReady |=> bValid && $stable(bResp))
	else
	begin
		failCount++;
		$error("write response dropped or changed before bReady");
	end

	rHeld: assert property (@(posedge clk) disable iff (reset)
		rValid && !rReady |=> rValid && $stable(rData))
	else
	begin
		failCount++;
		$error("read data dropped or changed before rReady");
	end

	busyDoneExclusive: assert property (@(posedge clk) disable iff (reset) !(busy && done))
	else
	begin
		failCount++;
		$error("busy and done set together");
	end

	// three pipeline stages plus the latch in control.
	doneAfterRun: assert property (@(posedge clk) disable iff (reset) runValid |-> ##4 $rose(done))
	else
	begin
		failCount++;
		$error("done did not rise four cycles after runValid");
	end

endmodule

bind layerControl nnLayer_assert uAssert (
	.clk(clk),
	.reset(reset),
	.bValid(bValid),
	.bReady(bReady),
	.bResp(bResp),
	.rValid(rValid),
	.rReady(rReady),
	.rData(rData),
	.busy(busy),
	.done(done),
	.runValid(runValid)
);

// ==== verilog/layerControl.sv ====
`include "nnLayer_params.svh"

module layerControl
	import nnLayerPkg::*;
(
	input  logic clk,
	input  logic reset,
	input  regAddrT awAddr,
	input  logic awValid,
	output logic awReady,
	input  logic [`NN_AXI_DATA_W-1:0] wData,
	input  logic wValid,
	output logic wReady,
	output logic [1:0] bResp,
	output logic bValid,
	input  logic bReady,
	input  regAddrT arAddr,
	input  logic arValid,
	output logic arReady,
	output logic [`NN_AXI_DATA_W-1:0] rData,
	output logic [1:0] rResp,
	output logic rValid,
	input  logic rReady,
	output actVecT activations,
	output logic runValid,
	input  logic neuronValid,
	input  resultT neuronResult [`NN_NEURONS],
	output logic wrEn,
	output logic [$clog2(`NN_NEURONS)-1:0] wrNeuron,
	output logic [$clog2(`NN_INPUTS+1)-1:0] wrIndex,
	output weightT wrData,
	output logic [$clog2(`NN_NEURONS)-1:0] rdNeuron,
	output logic [$clog2(`NN_INPUTS+1)-1:0] rdIndex,
	input  weightT bankRdData
);
	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	typedef enum logic {IDLE, BUSY} stateT;

	stateT state;
	logic busy;
	logic done;
	resultT results [`NN_NEURONS];
	logic wrFire;
	logic rdFire;
	logic wActHit, wCtrlHit, wWeightHit;
	regAddrT awOff, awWOff, arOff, arROff, arWOff;
	logic [`NN_AXI_DATA_W-1:0] rdWord;
	logic rdOk;

	// aligned word inside [base, base + 4 * words).
	function automatic logic inRange(regAddrT a, int base, int words);
		return (a[1:0] == 2'b00) && (int'(a) >= base) && (int'(a) < base + 4 * words);
	endfunction

	assign wrFire = awReady & awValid & wValid;
	assign rdFire = arReady & arValid;
	assign wReady = awReady; // address and data taken together.

	// write decode.
	assign awOff = awAddr - `NN_ACT_BASE;
	assign awWOff = awAddr - `NN_WEIGHT_BASE;
	assign wActHit = inRange(awAddr, `NN_ACT_BASE, `NN_INPUTS);
	assign wCtrlHit = (awAddr == `NN_CTRL_ADDR);
	assign wWeightHit = inRange(awAddr, `NN_WEIGHT_BASE, `NN_NEURONS * (`NN_INPUTS + 1));

	assign wrEn = wrFire & wWeightHit;
	assign wrNeuron = awWOff[6 +: $bits(wrNeuron)];
	assign wrIndex = awWOff[2 +: $bits(wrIndex)];
	assign wrData = weightT'(wData[`NN_DATA_W-1:0]);

	// read decode, weight byte comes back from the bank in the same cycle.
	assign arOff = arAddr - `NN_ACT_BASE;
	assign arROff = arAddr - `NN_RESULT_BASE;
	assign arWOff = arAddr - `NN_WEIGHT_BASE;
	assign rdNeuron = arWOff[6 +: $bits(rdNeuron)];
	assign rdIndex = arWOff[2 +: $bits(rdIndex)];

	always_comb
	begin
		rdWord = '0;
		rdOk = 1'b1;
		if (inRange(arAddr, `NN_ACT_BASE, `NN_INPUTS))
			rdWord[`NN_DATA_W-1:0] = activations[arOff[5:2]];
		else if (arAddr == `NN_CTRL_ADDR)
			rdWord = '0; // write-only bit.
		else if (arAddr == `NN_STATUS_ADDR)
			rdWord[1:0] = {done, busy};
		else if (inRange(arAddr, `NN_RESULT_BASE, `NN_NEURONS))
			rdWord[`NN_DATA_W-1:0] = results[arROff[2 +: $bits(rdNeuron)]];
		else if (inRange(arAddr, `NN_WEIGHT_BASE, `NN_NEURONS * (`NN_INPUTS + 1)))
			rdWord[`NN_DATA_W-1:0] = bankRdData;
		else
			rdOk = 1'b0;
	end

	// write channel and activation registers.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			awReady <= 1'b0;
			bValid <= 1'b0;
			activations <= '{default: '0};
		end
		else
		begin
			awReady <= awValid & wValid & ~awReady & ~bValid;
			if (wrFire)
				bValid <= 1'b1;
			else if (bReady)
				bValid <= 1'b0;
			if (wrFire && wActHit)
				activations[awOff[5:2]] <= activationT'(wData[`NN_DATA_W-1:0]);
		end
	end

	always_ff @(posedge clk)
	begin
		if (wrFire)
			bResp <= (wActHit | wCtrlHit | wWeightHit) ? RESP_OKAY : RESP_SLVERR;
	end

	// read channel.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			arReady <= 1'b0;
			rValid <= 1'b0;
		end
		else
		begin
			arReady <= arValid & ~arReady & ~rValid;
			if (rdFire)
				rValid <= 1'b1;
			else if (rReady)
				rValid <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rdFire)
		begin
			rData <= rdWord;
			rResp <= rdOk ? RESP_OKAY : RESP_SLVERR;
		end
	end

	// run sequencing.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= IDLE;
			runValid <= 1'b0;
			done <= 1'b0;
			results <= '{default: '0};
		end
		else
		begin
			runValid <= 1'b0;
			case (state)
				IDLE:
					if (wrFire && wCtrlHit && wData[0])
					begin
						state <= BUSY;
						runValid <= 1'b1;
						done <= 1'b0;
					end
				BUSY:
					if (neuronValid) // all neurons share one latency.
					begin
						results <= neuronResult;
						done <= 1'b1;
						state <= IDLE;
					end
				default:
					state <= IDLE;
			endcase
		end
	end

	assign busy = (state == BUSY);

endmodule

// ==== verilog/neuronNode.sv ====
`include "nnLayer_params.svh"

module neuronNode
	import nnLayerPkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic validIn,
	input  actVecT activations,
	input  weightVecT weights,
	input  weightT bias,
	output logic validOut,
	output resultT result
);
	actVecT actReg;
	logic validAct;
	logic validSum;
	activationT sumNext;
	activationT sumReg;

	// each product cut to its low byte, then everything wraps mod 256.
	always_comb
	begin
		sumNext = bias;
		for (int i = 0; i < `NN_INPUTS; i++)
			sumNext = sumNext + activationT'(actReg[i] * weights[i]);
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			validAct <= 1'b0;
			validSum <= 1'b0;
			validOut <= 1'b0;
		end
		else
		begin
			validAct <= validIn;
			validSum <= validAct;
			validOut <= validSum;
		end
	end

	always_ff @(posedge clk)
	begin
		actReg <= activations; // stage 1.
		sumReg <= sumNext; // stage 2.
		result <= sumReg[`NN_DATA_W-1] ? '0 : resultT'(sumReg); // relu.
	end

endmodule

// ==== verilog/nnLayer.sv ====
`include "nnLayer_params.svh"

module nnLayer
	import nnLayerPkg::*;
(
	input  logic clk,
	input  logic reset,
	input  regAddrT awAddr,
	input  logic awValid,
	output logic awReady,
	input  logic [`NN_AXI_DATA_W-1:0] wData,
	input  logic wValid,
	output logic wReady,
	output logic [1:0] bResp,
	output logic bValid,
	input  logic bReady,
	input  regAddrT arAddr,
	input  logic arValid,
	output logic arReady,
	output logic [`NN_AXI_DATA_W-1:0] rData,
	output logic [1:0] rResp,
	output logic rValid,
	input  logic rReady
);
	actVecT activations;
	logic runValid;
	logic wrEn;
	logic [$clog2(`NN_NEURONS)-1:0] wrNeuron;
	logic [$clog2(`NN_INPUTS+1)-1:0] wrIndex;
	weightT wrData;
	logic [$clog2(`NN_NEURONS)-1:0] rdNeuron;
	logic [$clog2(`NN_INPUTS+1)-1:0] rdIndex;
	weightT bankRdData;
	weightVecT weights [`NN_NEURONS];
	weightT biases [`NN_NEURONS];
	logic [`NN_NEURONS-1:0] validVec;
	resultT neuronResult [`NN_NEURONS];

	layerControl uControl (
		.clk, .reset,
		.awAddr, .awValid, .awReady,
		.wData, .wValid, .wReady,
		.bResp, .bValid, .bReady,
		.arAddr, .arValid, .arReady,
		.rData, .rResp, .rValid, .rReady,
		.activations, .runValid,
		.neuronValid(validVec[0]), // neuron 0 stands for all.
		.neuronResult,
		.wrEn, .wrNeuron, .wrIndex, .wrData,
		.rdNeuron, .rdIndex, .bankRdData
	);

	weightBank uBank (
		.clk, .reset,
		.wrEn, .wrNeuron, .wrIndex, .wrData,
		.rdNeuron, .rdIndex,
		.rdData(bankRdData),
		.weights, .biases
	);

	for (genvar n = 0; n < `NN_NEURONS; n++)
	begin : gNeuron
		neuronNode uNode (
			.clk, .reset,
			.validIn(runValid),
			.activations,
			.weights(weights[n]),
			.bias(biases[n]),
			.validOut(validVec[n]),
			.result(neuronResult[n])
		);
	end

endmodule

// ==== verilog/nnLayerPkg.sv ====
`include "nnLayer_params.svh"

package nnLayerPkg;

	// one activation byte.
	typedef logic signed [`NN_DATA_W-1:0] activationT;

	// one weight or bias byte.
	typedef logic signed [`NN_DATA_W-1:0] weightT;

	// full input vector of a neuron.
	typedef activationT actVecT [`NN_INPUTS];

	typedef weightT weightVecT [`NN_INPUTS];

	// relu output, never negative.
	typedef logic [`NN_DATA_W-1:0] resultT;

	// byte address on the register port.
	typedef logic [`NN_ADDR_W-1:0] regAddrT;

endpackage

// ==== verilog/nnLayer_params.svh ====
`ifndef NN_LAYER_PARAMS_SVH
`define NN_LAYER_PARAMS_SVH

// layer geometry.
`define NN_INPUTS 15
`define NN_NEURONS 4
`define NN_DATA_W 8

// bus widths.
`define NN_ADDR_W 12
`define NN_AXI_DATA_W 32

`define NN_CTRL_ADDR 12'h040 // bit 0 starts a run.
`define NN_STATUS_ADDR 12'h044 // bit 0 busy, bit 1 done.

// word arrays, 4 bytes apart.
`define NN_ACT_BASE 12'h000
`define NN_RESULT_BASE 12'h080
`define NN_WEIGHT_BASE 12'h100 // 64 bytes per neuron, slot 15 is the bias.

`endif

// ==== verilog/weightBank.sv ====
`include "nnLayer_params.svh"

module weightBank
	import nnLayerPkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic wrEn,
	input  logic [$clog2(`NN_NEURONS)-1:0] wrNeuron,
	input  logic [$clog2(`NN_INPUTS+1)-1:0] wrIndex,
	input  weightT wrData,
	input  logic [$clog2(`NN_NEURONS)-1:0] rdNeuron,
	input  logic [$clog2(`NN_INPUTS+1)-1:0] rdIndex,
	output weightT rdData,
	output weightVecT weights [`NN_NEURONS],
	output weightT biases [`NN_NEURONS]
);
	localparam int SLOTS = `NN_INPUTS + 1;

	// weights in slots 0..14, bias in the last slot.
	weightT bank [`NN_NEURONS][SLOTS];

	always_ff @(posedge clk)
	begin
		if (reset)
			bank <= '{default: '0};
		else if (wrEn)
			bank[wrNeuron][wrIndex] <= wrData;
	end

	assign rdData = bank[rdNeuron][rdIndex]; // bus read-back.

	always_comb
	begin
		for (int n = 0; n < `NN_NEURONS; n++)
		begin
			for (int i = 0; i < `NN_INPUTS; i++)
				weights[n][i] = bank[n][i];
			biases[n] = bank[n][`NN_INPUTS];
		end
	end

endmodule
